// File: source/alu_pkg.sv
// ##################
// Fixed 16-bit width, four slices; flag bits sit just above the result
// ##################

package alu_pkg;

  // Datapath size
  localparam int data_width   = 16;
  localparam int nibble_count = 4;

  // Word addresses on the Wishbone bus
  localparam logic [1:0] addr_operand_a = 2'd0;
  localparam logic [1:0] addr_operand_b = 2'd1;
  localparam logic [1:0] addr_control   = 2'd2;
  // Read only, writes are acknowledged and dropped
  localparam logic [1:0] addr_result    = 2'd3;

  // Control word layout
  localparam int ctrl_select_lsb = 0;
  localparam int ctrl_mode_bit   = 4;
  localparam int ctrl_carry_bit  = 5;

  // Flag positions in the result read word
  localparam int flag_carry = 16;
  localparam int flag_zero  = 17;
  localparam int flag_sign  = 18;
  localparam int flag_equal = 19;

endpackage

// File: source/alu_slice.sv
// ##################
// Active-high data, no carry input; the carry is applied in result_combine
// ##################
`timescale 1ns/1ps

module alu_slice
(
  input  logic [3:0] a,
  input  logic [3:0] b,
  input  logic [3:0] select,
  input  logic       mode,
  output logic [3:0] bit_p,
  output logic [3:0] bit_g,
  output logic       group_g,
  output logic       group_p
);

  logic [3:0] b_gen;
  logic [3:0] b_prop;
  logic       nibble_g;
  logic       nibble_p;

  // B or not B as picked by the upper select pair
  assign b_gen  = ({4{select[3]}} & b) | ({4{select[2]}} & ~b);

  // Same choice for the lower select pair
  assign b_prop = ({4{select[0]}} & b) | ({4{select[1]}} & ~b);

  // Inner terms of the 74181, generate implies propagate
  assign bit_g = a & b_gen;
  assign bit_p = a | b_prop;

  // Nibble generate, highest bit first
  assign nibble_g = bit_g[3]
                  | (bit_p[3] & bit_g[2])
                  | (bit_p[3] & bit_p[2] & bit_g[1])
                  | (bit_p[3] & bit_p[2] & bit_p[1] & bit_g[0]);

  assign nibble_p = &bit_p;

  // Logic mode builds no carries across nibbles
  assign group_g = nibble_g & ~mode;
  assign group_p = nibble_p & ~mode;

endmodule

// File: source/carry_lookahead.sv
// ##################
// Single lookahead level, no cascade group outputs
// ##################
`timescale 1ns/1ps

module carry_lookahead
(
  input  logic [3:0] group_g,
  input  logic [3:0] group_p,
  input  logic       carry_in,
  output logic [3:0] nibble_carry,
  output logic       carry_out
);

  // Carry into the lowest nibble is the ALU carry in
  assign nibble_carry[0] = carry_in;

  assign nibble_carry[1] = group_g[0]
                         | (group_p[0] & carry_in);

  assign nibble_carry[2] = group_g[1]
                         | (group_p[1] & group_g[0])
                         | (group_p[1] & group_p[0] & carry_in);

  assign nibble_carry[3] = group_g[2]
                         | (group_p[2] & group_g[1])
                         | (group_p[2] & group_p[1] & group_g[0])
                         | (group_p[2] & group_p[1] & group_p[0] & carry_in);

  // Out of the top nibble, all terms flat as in the 74182
  assign carry_out = group_g[3]
                   | (group_p[3] & group_g[2])
                   | (group_p[3] & group_p[2] & group_g[1])
                   | (group_p[3] & group_p[2] & group_p[1] & group_g[0])
                   | (group_p[3] & group_p[2] & group_p[1] & group_p[0] & carry_in);

endmodule

// File: source/result_combine.sv
// ##################
// Ripples carries only inside a nibble; nibble carries come from lookahead
// ##################
`timescale 1ns/1ps

module result_combine
(
  input  logic [15:0] bit_p,
  input  logic [15:0] bit_g,
  input  logic [3:0]  nibble_carry,
  input  logic        carry_out,
  input  logic        mode,
  output logic [15:0] result,
  output logic [3:0]  flags
);

  logic [15:0] half;
  logic [15:0] bit_carry;
  logic        ripple;

  assign half = bit_p ^ bit_g;

  // Carry into every bit, starting from its nibble carry
  always_comb
  begin
    ripple = 1'b0;
    for (int n = 0; n < alu_pkg::nibble_count; n++)
    begin
      ripple = nibble_carry[n];
      for (int j = 0; j < 4; j++)
      begin
        bit_carry[4*n + j] = ripple;
        ripple = bit_g[4*n + j] | (bit_p[4*n + j] & ripple);
      end
    end
  end

  // In logic mode the inner carry sits at the idle level,
  // which leaves the inverted half term as the result
  assign result = half ^ (bit_carry | {alu_pkg::data_width{mode}});

  assign flags[alu_pkg::flag_carry - alu_pkg::data_width] = carry_out & ~mode;
  assign flags[alu_pkg::flag_zero - alu_pkg::data_width]  = ~|result;
  assign flags[alu_pkg::flag_sign - alu_pkg::data_width]  = result[alu_pkg::data_width-1];
  // Comparator output, high on all ones
  assign flags[alu_pkg::flag_equal - alu_pkg::data_width] = &result;

endmodule

// File: source/wb_alu_regs.sv
// ##################
// Wishbone classic, one ack per access; no byte selects, no err or rty
// ##################
`timescale 1ns/1ps

module wb_alu_regs
(
  input  logic        clk,
  input  logic        reset,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [1:0]  wb_adr,
  input  logic [31:0] wb_dat_w,
  output logic [31:0] wb_dat_r,
  output logic        wb_ack,
  output logic [15:0] operand_a,
  output logic [15:0] operand_b,
  output logic [3:0]  select,
  output logic        mode,
  output logic        carry_in,
  input  logic [15:0] result,
  input  logic [3:0]  flags
);

  logic        access;
  logic [15:0] result_q;
  logic [3:0]  flags_q;
  logic [31:0] read_word;

  // New access only while no ack is out, so ack never lasts two cycles
  assign access = wb_cyc & wb_stb & ~wb_ack;

  always_ff @(posedge clk)
  begin
    if (reset)
      wb_ack <= 1'b0;
    else
      wb_ack <= access;
  end

  // Register writes land on the same edge that raises ack
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      operand_a <= '0;
      operand_b <= '0;
      select    <= '0;
      mode      <= 1'b0;
      carry_in  <= 1'b0;
    end
    else if (access && wb_we)
    begin
      case (wb_adr)
        alu_pkg::addr_operand_a: operand_a <= wb_dat_w[alu_pkg::data_width-1:0];
        alu_pkg::addr_operand_b: operand_b <= wb_dat_w[alu_pkg::data_width-1:0];
        alu_pkg::addr_control:
        begin
          select   <= wb_dat_w[alu_pkg::ctrl_select_lsb +: 4];
          mode     <= wb_dat_w[alu_pkg::ctrl_mode_bit];
          carry_in <= wb_dat_w[alu_pkg::ctrl_carry_bit];
        end
        default:
        begin
          // Result word ignores writes
        end
      endcase
    end
  end

  // Datapath output sampled every cycle
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      result_q <= '0;
      flags_q  <= '0;
    end
    else
    begin
      result_q <= result;
      flags_q  <= flags;
    end
  end

  always_comb
  begin
    read_word = '0;
    case (wb_adr)
      alu_pkg::addr_operand_a: read_word[alu_pkg::data_width-1:0] = operand_a;
      alu_pkg::addr_operand_b: read_word[alu_pkg::data_width-1:0] = operand_b;
      alu_pkg::addr_control:
      begin
        read_word[alu_pkg::ctrl_select_lsb +: 4] = select;
        read_word[alu_pkg::ctrl_mode_bit]        = mode;
        read_word[alu_pkg::ctrl_carry_bit]       = carry_in;
      end
      alu_pkg::addr_result:
      begin
        read_word[alu_pkg::data_width-1:0] = result_q;
        read_word[alu_pkg::flag_carry +: 4] = flags_q;
      end
      default: read_word = '0;
    endcase
  end

  // Read data loads with ack and holds while ack is high
  always_ff @(posedge clk)
  begin
    if (access)
      wb_dat_r <= read_word;
  end

endmodule

// File: source/bitslice_alu_top.sv
// ##################
// Result word trails a control or operand write by one extra clock
// ##################
`timescale 1ns/1ps

module bitslice_alu_top
(
  input  logic        clk,
  input  logic        reset,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [1:0]  wb_adr,
  input  logic [31:0] wb_dat_w,
  output logic [31:0] wb_dat_r,
  output logic        wb_ack
);

  logic [15:0] operand_a;
  logic [15:0] operand_b;
  logic [3:0]  select;
  logic        mode;
  logic        carry_in;
  logic [15:0] bit_p;
  logic [15:0] bit_g;
  logic [3:0]  group_g;
  logic [3:0]  group_p;
  logic [3:0]  nibble_carry;
  logic        carry_out;
  logic [15:0] result;
  logic [3:0]  flags;

  wb_alu_regs u_regs
  (
    .clk       (clk),
    .reset     (reset),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .select    (select),
    .mode      (mode),
    .carry_in  (carry_in),
    .result    (result),
    .flags     (flags)
  );

  // One slice per nibble, all fed the same select and mode
  for (genvar n = 0; n < alu_pkg::nibble_count; n++)
  begin : g_slice
    alu_slice u_slice
    (
      .a       (operand_a[4*n +: 4]),
      .b       (operand_b[4*n +: 4]),
      .select  (select),
      .mode    (mode),
      .bit_p   (bit_p[4*n +: 4]),
      .bit_g   (bit_g[4*n +: 4]),
      .group_g (group_g[n]),
      .group_p (group_p[n])
    );
  end

  carry_lookahead u_lookahead
  (
    .group_g      (group_g),
    .group_p      (group_p),
    .carry_in     (carry_in),
    .nibble_carry (nibble_carry),
    .carry_out    (carry_out)
  );

  result_combine u_combine
  (
    .bit_p        (bit_p),
    .bit_g        (bit_g),
    .nibble_carry (nibble_carry),
    .carry_out    (carry_out),
    .mode         (mode),
    .result       (result),
    .flags        (flags)
  );

endmodule

// File: tests/bitslice_alu_sva.sv
// ####################
// Samples on the cycle after ack rises, so read data is already loaded
// ####################
`timescale 1ns/1ps

module bitslice_alu_sva
(
  input logic        clk,
  input logic        reset,
  input logic        wb_cyc,
  input logic        wb_stb,
  input logic        wb_we,
  input logic [1:0]  wb_adr,
  input logic [31:0] wb_dat_r,
  input logic        wb_ack
);

  // Single cycle ack pulses
  assert property (@(posedge clk) disable iff (reset) wb_ack |=> !wb_ack)
    else $error("ack held high for two cycles");

  assert property (@(posedge clk) disable iff (reset) $rose(wb_ack) |-> $past(wb_cyc && wb_stb))
    else $error("ack raised without a pending access");

  // Flags in the result word must match its own result bits
  assert property (@(posedge clk) disable iff (reset)
    (wb_ack && $past(wb_adr == alu_pkg::addr_result && !wb_we))
    |-> (wb_dat_r[alu_pkg::flag_zero] == (wb_dat_r[15:0] == 16'h0000))
        && (wb_dat_r[alu_pkg::flag_sign] == wb_dat_r[15]))
    else $error("zero or sign flag disagrees with the result");

endmodule

bind bitslice_alu_top bitslice_alu_sva u_sva
(
  .clk      (clk),
  .reset    (reset),
  .wb_cyc   (wb_cyc),
  .wb_stb   (wb_stb),
  .wb_we    (wb_we),
  .wb_adr   (wb_adr),
  .wb_dat_r (wb_dat_r),
  .wb_ack   (wb_ack)
);

// File: tests/tb_bitslice_alu.sv
// ####################
// Directed tests only; every bus access gives up after 20 cycles without ack
// ####################
`timescale 1ns/1ps

module tb_bitslice_alu;

  localparam int test_count = 5;

  logic        clk;
  logic        reset;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [1:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  int          errors;
  int          checks;
  logic [31:0] lcg_state;

  bitslice_alu_top uut
  (
    .clk      (clk),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Watchdog, 2 us per test
  initial
  begin
    #(test_count * 2000);
    $display("Watchdog expired before the tests completed");
    $display("Result: FAILED");
    $finish;
  end

  function automatic logic [15:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    if (got !== expected)
    begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, expected);
      errors++;
    end
  endtask

  // Called 1 ns after an edge with the request already driven
  task automatic wait_ack(input string what);
    int waited;
    waited = 0;
    @(posedge clk);
    #1;
    while (!wb_ack && waited < 20)
    begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!wb_ack)
    begin
      $display("No acknowledge within 20 cycles for %s", what);
      errors++;
    end
  endtask

  task automatic wb_write(input logic [1:0] adr, input logic [31:0] data);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = data;
    wait_ack("a write");
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_read(input logic [1:0] adr, output logic [31:0] data);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    wait_ack("a read");
    data   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  task automatic run_op(input logic [15:0] a, input logic [15:0] b, input logic [3:0] sel,
                        input logic mode, input logic cin, output logic [31:0] word);
    logic [31:0] ctrl;
    ctrl = 32'h0;
    ctrl[alu_pkg::ctrl_select_lsb +: 4] = sel;
    ctrl[alu_pkg::ctrl_mode_bit]        = mode;
    ctrl[alu_pkg::ctrl_carry_bit]       = cin;
    wb_write(alu_pkg::addr_operand_a, {16'h0000, a});
    wb_write(alu_pkg::addr_operand_b, {16'h0000, b});
    wb_write(alu_pkg::addr_control, ctrl);
    wb_read(alu_pkg::addr_result, word);
  endtask

  // Flags follow from the expected result alone, plus the carry
  task automatic check_alu(input logic [31:0] word, input logic [15:0] res, input logic carry);
    logic [3:0] flags;
    flags = 4'b0000;
    flags[alu_pkg::flag_carry - 16] = carry;
    flags[alu_pkg::flag_zero - 16]  = (res == 16'h0000);
    flags[alu_pkg::flag_sign - 16]  = res[15];
    flags[alu_pkg::flag_equal - 16] = (res == 16'hffff);
    check_value("result", {16'h0000, word[15:0]}, {16'h0000, res});
    check_value("flags", {28'h0, word[19:16]}, {28'h0, flags});
  endtask

  task automatic test_reset_and_access();
    logic [31:0] word;
    wb_read(alu_pkg::addr_result, word);
    check_value("result word after reset", word, 32'h0002_0000);
    wb_write(alu_pkg::addr_operand_a, 32'hdead_beef);
    wb_read(alu_pkg::addr_operand_a, word);
    check_value("operand_a", word, 32'h0000_beef);
    wb_write(alu_pkg::addr_operand_b, 32'h1234_5678);
    wb_read(alu_pkg::addr_operand_b, word);
    check_value("operand_b", word, 32'h0000_5678);
    // Only select, mode and carry in survive
    wb_write(alu_pkg::addr_control, 32'hffff_ffff);
    wb_read(alu_pkg::addr_control, word);
    check_value("control", word, 32'h0000_003f);
    wb_write(alu_pkg::addr_result, 32'h5a5a_5a5a);
    wb_read(alu_pkg::addr_result, word);
    // Select 1111 in logic mode passes A, sign from bit 15
    check_value("result word after result write", word, 32'h0004_beef);
    wb_read(alu_pkg::addr_control, word);
    check_value("control after result write", word, 32'h0000_003f);
  endtask

  task automatic test_addition();
    logic [15:0] a;
    logic [15:0] b;
    logic [16:0] sum;
    logic [31:0] word;
    for (int c = 0; c < 2; c++)
    begin
      for (int i = 0; i < 20; i++)
      begin
        a   = next_random();
        b   = next_random();
        sum = {1'b0, a} + {1'b0, b} + 17'(c);
        run_op(a, b, 4'b1001, 1'b0, c[0], word);
        check_alu(word, sum[15:0], sum[16]);
      end
    end
  endtask

  task automatic test_subtraction();
    logic [15:0] a;
    logic [15:0] b;
    logic [31:0] word;
    for (int c = 0; c < 2; c++)
    begin
      for (int i = 0; i < 8; i++)
      begin
        a = next_random();
        b = next_random();
        run_op(a, b, 4'b0110, 1'b0, c[0], word);
        // No borrow when A plus carry in reaches past B
        check_alu(word, a - b - 16'd1 + 16'(c), ({1'b0, a} + 17'(c)) > {1'b0, b});
      end
    end
    a = next_random();
    run_op(a, a, 4'b0110, 1'b0, 1'b0, word);
    check_alu(word, 16'hffff, 1'b0);
    check_value("equal flag", {31'h0, word[alu_pkg::flag_equal]}, 32'h1);
  endtask

  task automatic test_logic();
    logic [3:0]  sels [4];
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] expected;
    logic [31:0] word;
    sels = '{4'b0110, 4'b1011, 4'b1110, 4'b0000};
    for (int f = 0; f < 4; f++)
    begin
      for (int i = 0; i < 6; i++)
      begin
        a = next_random();
        b = next_random();
        case (sels[f])
          4'b0110: expected = a ^ b;
          4'b1011: expected = a & b;
          4'b1110: expected = a | b;
          default: expected = ~a;
        endcase
        // Carry in alternates and must never reach the carry flag
        run_op(a, b, sels[f], 1'b1, i[0], word);
        check_alu(word, expected, 1'b0);
      end
    end
  endtask

  task automatic test_carry_chains();
    logic [31:0] word;
    run_op(16'hffff, 16'h0000, 4'b1001, 1'b0, 1'b1, word);
    check_alu(word, 16'h0000, 1'b1);
    run_op(16'h7fff, 16'h0001, 4'b1001, 1'b0, 1'b0, word);
    check_alu(word, 16'h8000, 1'b0);
  endtask

  initial
  begin
    errors    = 0;
    checks    = 0;
    lcg_state = 32'h7ead;
    reset     = 1'b1;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = 2'd0;
    wb_dat_w  = 32'h0;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    // Result register loads the idle datapath once
    @(posedge clk);
    #1;
    test_reset_and_access();
    test_addition();
    test_subtraction();
    test_logic();
    test_carry_chains();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

// File: bitslice_alu.f
source/alu_pkg.sv
source/alu_slice.sv
source/carry_lookahead.sv
source/result_combine.sv
source/wb_alu_regs.sv
source/bitslice_alu_top.sv
tests/bitslice_alu_sva.sv
tests/tb_bitslice_alu.sv

// File: Makefile
TOP = tb_bitslice_alu

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f bitslice_alu.f -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir
